// File: tb/wrb_cases.txt
# W lines: name W pc alu dmem csr rd wr_req sel expected_wrb_data
# R lines: name R rs1 rs2 expected_rs1 expected_rs2 (all numbers in hex)
rst_lo R 01 02 00000000 00000000
rst_hi R 1e 1f 00000000 00000000
sel_alu W 00001000 12345678 deadbeef 0badf00d 01 1 0 12345678
sel_incpc W 00001000 12345678 deadbeef 0badf00d 02 1 1 00001004
sel_mem W 00001000 12345678 deadbeef 0badf00d 03 1 2 deadbeef
sel_csr W 00001000 12345678 deadbeef 0badf00d 04 1 3 0badf00d
rb_x1_x2 R 01 02 12345678 00001004
rb_x3_x4 R 03 04 deadbeef 0badf00d
rb_untouched R 05 1f 00000000 00000000
pre_x5 W 00000000 a5a5a5a5 00000000 00000000 05 1 0 a5a5a5a5
rb_x5 R 05 05 a5a5a5a5 a5a5a5a5
incpc_wrap0 W fffffffc 11111111 22222222 33333333 05 1 1 00000000
incpc_wrap2 W fffffffe 11111111 22222222 33333333 06 1 1 00000002
incpc_sign W 7ffffffc 11111111 22222222 33333333 07 1 1 80000000
rb_wrap R 05 06 00000000 00000002
rb_sign R 07 00 80000000 00000000
x0_alu W 00000000 ffffffff 00000000 00000000 00 1 0 ffffffff
x0_mem W 00000000 00000000 cafef00d 00000000 00 1 2 cafef00d
x0_incpc W 00000010 00000000 00000000 00000000 00 1 1 00000014
rb_x0 R 00 00 00000000 00000000
nowr_x1 W 00002000 55555555 00000000 00000000 01 0 0 55555555
nowr_x8 W 00002000 00000000 00000000 66666666 08 0 3 66666666
rb_nowr R 01 08 12345678 00000000
ovw_x1 W 00002000 89abcdef 00000000 00000000 01 1 0 89abcdef
rb_ovw R 01 02 89abcdef 00001004
x31_mem W 00003000 00000000 fedcba98 00000000 1f 1 2 fedcba98
x30_csr W 00003000 00000000 00000000 00c0ffee 1e 1 3 00c0ffee
rb_x31 R 1f 1e fedcba98 00c0ffee
rb_x31_dual R 1f 1f fedcba98 fedcba98
b2b_x9a W 00004000 00000099 00000000 00000000 09 1 0 00000099
b2b_x9b W 00004004 00000999 00000000 00000000 09 1 0 00000999
rb_x9 R 09 04 00000999 0badf00d
mix_x10 W 00005000 00000000 13579bdf 2468ace0 0a 1 2 13579bdf
mix_x11 W 00005000 00000000 13579bdf 2468ace0 0b 1 3 2468ace0
rb_mix R 0a 0b 13579bdf 2468ace0
rb_final R 03 1e deadbeef 00c0ffee

// File: wrb_subsys.f
+incdir+design
design/pcore_wrb_pkg.sv
design/mem2wrb_if.sv
design/mem2wrb_capture.sv
design/writeback.sv
design/regfile_bypass.sv
design/wrb_subsys.sv
tb/wrb_subsys_tb.sv

// File: Bender.yml
package:
  name: wrb_subsys

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/pcore_wrb_pkg.sv
      - design/mem2wrb_if.sv
      - design/mem2wrb_capture.sv
      - design/writeback.sv
      - design/regfile_bypass.sv
      - design/wrb_subsys.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - tb/wrb_subsys_tb.sv

// File: tb/wrb_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcore_wrb_cfg.svh"

module wrb_subsys_tb;
    import pcore_wrb_pkg::*;

    localparam int ACK_TIMEOUT = 100;

    logic           clk;
    logic           reset_i;
    logic           req_i;
    logic           ack_o;
    type_data_t     pc_i;
    type_data_t     alu_result_i;
    type_data_t     dmem_rdata_i;
    type_data_t     csr_data_i;
    type_reg_addr_t rd_addr_i;
    logic           rd_wr_req_i;
    logic [1:0]     rd_wrb_sel_i;
    type_reg_addr_t rs1_addr_i;
    type_reg_addr_t rs2_addr_i;
    type_data_t     rs1_data_o;
    type_data_t     rs2_data_o;
    type_data_t     wrb_rd_data_o;

    // Expected register contents, updated after every committed write
    type_data_t model_regs [0:`PCORE_NREGS-1];
    integer     seed;
    int         valid_seen;

    wrb_subsys u_wrb_subsys (
        .clk           (clk),
        .reset_i       (reset_i),
        .req_i         (req_i),
        .ack_o         (ack_o),
        .pc_i          (pc_i),
        .alu_result_i  (alu_result_i),
        .dmem_rdata_i  (dmem_rdata_i),
        .csr_data_i    (csr_data_i),
        .rd_addr_i     (rd_addr_i),
        .rd_wr_req_i   (rd_wr_req_i),
        .rd_wrb_sel_i  (rd_wrb_sel_i),
        .rs1_addr_i    (rs1_addr_i),
        .rs2_addr_i    (rs2_addr_i),
        .rs1_data_o    (rs1_data_o),
        .rs2_data_o    (rs2_data_o),
        .wrb_rd_data_o (wrb_rd_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input logic [8*24-1:0] case_name, input string what,
                               input type_data_t expected, input type_data_t actual);
        if (actual !== expected) begin
            $display("Mismatch in %0s, %0s: expected %h, actual %h",
                     case_name, what, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    // Outputs are sampled on the falling edge, away from the driving edge
    task automatic sample_cycle();
        @(negedge clk);
        if (u_wrb_subsys.u_mem2wrb_if.valid === 1'b1) begin
            valid_seen++;
        end
    endtask

    task automatic wait_ack(input logic level, input string phase, output int cycles);
        cycles = 0;
        do begin
            sample_cycle();
            cycles++;
        end while ((ack_o !== level) && (cycles < ACK_TIMEOUT));
        if (ack_o !== level) begin
            $display("Handshake hung in the %0s phase, ack_o never went to %0d",
                     phase, level);
            $display("TEST FAILED");
            $fatal(1, "handshake timeout");
        end
    endtask

    task automatic run_write_case(input logic [8*24-1:0] case_name,
                                  input type_data_t pc, input type_data_t alu,
                                  input type_data_t mem, input type_data_t csr,
                                  input type_reg_addr_t rd, input logic wr,
                                  input logic [1:0] sel, input type_data_t expected,
                                  input int hold);
        int         cycles;
        type_data_t exp_rs1;
        valid_seen = 0;
        @(posedge clk);
        pc_i         <= pc;
        alu_result_i <= alu;
        dmem_rdata_i <= mem;
        csr_data_i   <= csr;
        rd_addr_i    <= rd;
        rd_wr_req_i  <= wr;
        rd_wrb_sel_i <= sel;
        req_i        <= 1'b1;
        // Point rs1 at the destination so the bypass shows while valid is high
        rs1_addr_i   <= rd;
        // req is sampled at the next edge, ack shows by the second falling edge
        wait_ack(1'b1, "request", cycles);
        check_value(case_name, "ack rise latency", 2, cycles);
        check_value(case_name, "wrb_rd_data_o", expected, wrb_rd_data_o);
        if (rd == '0) begin
            exp_rs1 = '0;
        end else if (wr) begin
            exp_rs1 = expected;
        end else begin
            exp_rs1 = model_regs[rd];
        end
        check_value(case_name, "rs1 bypass", exp_rs1, rs1_data_o);
        repeat (hold) begin
            @(posedge clk);
            sample_cycle();
            check_value(case_name, "ack_o held", 1, ack_o);
        end
        @(posedge clk);
        req_i <= 1'b0;
        wait_ack(1'b0, "release", cycles);
        check_value(case_name, "ack fall latency", 2, cycles);
        check_value(case_name, "valid cycles", 1, valid_seen);
        check_value(case_name, "rs1 after write", exp_rs1, rs1_data_o);
        if (wr && (rd != '0)) begin
            model_regs[rd] = expected;
        end
    endtask

    task automatic run_read_case(input logic [8*24-1:0] case_name,
                                 input type_reg_addr_t rs1, input type_reg_addr_t rs2,
                                 input type_data_t exp1, input type_data_t exp2);
        @(posedge clk);
        rs1_addr_i <= rs1;
        rs2_addr_i <= rs2;
        @(negedge clk);
        check_value(case_name, "rs1_data_o", exp1, rs1_data_o);
        check_value(case_name, "rs2_data_o", exp2, rs2_data_o);
    endtask

    initial begin
        int               fd;
        int               nf;
        int               idle;
        int               hold;
        int               n_write;
        int               n_read;
        logic [8*200-1:0] line_buf;
        logic [8*24-1:0]  case_name;
        logic [8*4-1:0]   kind;
        type_data_t       f_pc;
        type_data_t       f_alu;
        type_data_t       f_mem;
        type_data_t       f_csr;
        type_data_t       f_exp;
        type_data_t       f_exp2;
        type_reg_addr_t   f_rd;
        type_reg_addr_t   f_rs2;
        logic             f_wr;
        logic [1:0]       f_sel;

        seed         = 77756;
        n_write      = 0;
        n_read       = 0;
        reset_i      = 1'b1;
        req_i        = 1'b0;
        pc_i         = '0;
        alu_result_i = '0;
        dmem_rdata_i = '0;
        csr_data_i   = '0;
        rd_addr_i    = '0;
        rd_wr_req_i  = 1'b0;
        rd_wrb_sel_i = 2'b00;
        rs1_addr_i   = '0;
        rs2_addr_i   = '0;
        for (int i = 0; i < `PCORE_NREGS; i++) begin
            model_regs[i] = '0;
        end

        repeat (8) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        check_value("reset", "ack_o", 0, ack_o);

        fd = $fopen("tb/wrb_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the cases file tb/wrb_cases.txt");
            $display("TEST FAILED");
            $fatal(1, "missing cases file");
        end

        while (!$feof(fd)) begin
            line_buf  = '0;
            case_name = '0;
            kind      = '0;
            nf = $fgets(line_buf, fd);
            nf = $sscanf(line_buf, "%s %s", case_name, kind);
            if ((nf == 2) && (case_name != "#")) begin
                idle = $unsigned($random(seed)) % 4;
                hold = $unsigned($random(seed)) % 4;
                repeat (idle) @(posedge clk);
                if (kind == "W") begin
                    nf = $sscanf(line_buf, "%s %s %h %h %h %h %h %h %h %h", case_name, kind,
                                 f_pc, f_alu, f_mem, f_csr, f_rd, f_wr, f_sel, f_exp);
                    if (nf != 10) begin
                        $display("Malformed write line in the cases file: %0s", case_name);
                        $display("TEST FAILED");
                        $fatal(1, "bad cases file");
                    end
                    run_write_case(case_name, f_pc, f_alu, f_mem, f_csr, f_rd, f_wr,
                                   f_sel, f_exp, hold);
                    n_write++;
                end else if (kind == "R") begin
                    nf = $sscanf(line_buf, "%s %s %h %h %h %h", case_name, kind,
                                 f_rd, f_rs2, f_exp, f_exp2);
                    if (nf != 6) begin
                        $display("Malformed read line in the cases file: %0s", case_name);
                        $display("TEST FAILED");
                        $fatal(1, "bad cases file");
                    end
                    run_read_case(case_name, f_rd, f_rs2, f_exp, f_exp2);
                    n_read++;
                end else begin
                    $display("Unknown case kind %0s on case %0s", kind, case_name);
                    $display("TEST FAILED");
                    $fatal(1, "bad cases file");
                end
            end
        end
        $fclose(fd);

        if ((n_write == 0) || (n_read == 0)) begin
            $display("No write or no read cases were found in the cases file");
            $display("TEST FAILED");
            $fatal(1, "empty cases file");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule : wrb_subsys_tb

`default_nettype wire

// File: design/wrb_subsys.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcore_wrb_cfg.svh"

module wrb_subsys (
    input  logic                          clk,
    input  logic                          reset_i,

    // Four-phase link from the memory stage
    input  logic                          req_i,
    output logic                          ack_o,
    input  pcore_wrb_pkg::type_data_t     pc_i,
    input  pcore_wrb_pkg::type_data_t     alu_result_i,
    input  pcore_wrb_pkg::type_data_t     dmem_rdata_i,
    input  pcore_wrb_pkg::type_data_t     csr_data_i,
    input  pcore_wrb_pkg::type_reg_addr_t rd_addr_i,
    input  logic                          rd_wr_req_i,
    input  logic [1:0]                    rd_wrb_sel_i,

    // Register read ports
    input  pcore_wrb_pkg::type_reg_addr_t rs1_addr_i,
    input  pcore_wrb_pkg::type_reg_addr_t rs2_addr_i,
    output pcore_wrb_pkg::type_data_t     rs1_data_o,
    output pcore_wrb_pkg::type_data_t     rs2_data_o,

    // Feedback to execute
    output pcore_wrb_pkg::type_data_t     wrb_rd_data_o
);
    import pcore_wrb_pkg::*;

    type_wrb2id_fb_s  wrb2rf;
    type_rd_wrb_sel_e rd_wrb_sel;

    // Top level keeps a plain vector for the select
    assign rd_wrb_sel = type_rd_wrb_sel_e'(rd_wrb_sel_i);

    mem2wrb_if u_mem2wrb_if ();

    mem2wrb_capture u_mem2wrb_capture (
        .clk          (clk),
        .reset_i      (reset_i),
        .req_i        (req_i),
        .ack_o        (ack_o),
        .pc_i         (pc_i),
        .alu_result_i (alu_result_i),
        .dmem_rdata_i (dmem_rdata_i),
        .csr_data_i   (csr_data_i),
        .rd_addr_i    (rd_addr_i),
        .rd_wr_req_i  (rd_wr_req_i),
        .rd_wrb_sel_i (rd_wrb_sel),
        .mem2wrb      (u_mem2wrb_if.source)
    );

    writeback u_writeback (
        .mem2wrb       (u_mem2wrb_if.sink),
        .wrb2rf_o      (wrb2rf),
        .wrb_rd_data_o (wrb_rd_data_o)
    );

    regfile_bypass u_regfile_bypass (
        .clk        (clk),
        .reset_i    (reset_i),
        .wrb2rf_i   (wrb2rf),
        .rs1_addr_i (rs1_addr_i),
        .rs2_addr_i (rs2_addr_i),
        .rs1_data_o (rs1_data_o),
        .rs2_data_o (rs2_data_o)
    );

endmodule : wrb_subsys

`default_nettype wire

// File: design/regfile_bypass.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcore_wrb_cfg.svh"

module regfile_bypass (
    input  logic                           clk,
    input  logic                           reset_i,
    input  pcore_wrb_pkg::type_wrb2id_fb_s wrb2rf_i,
    input  pcore_wrb_pkg::type_reg_addr_t  rs1_addr_i,
    input  pcore_wrb_pkg::type_reg_addr_t  rs2_addr_i,
    output pcore_wrb_pkg::type_data_t      rs1_data_o,
    output pcore_wrb_pkg::type_data_t      rs2_data_o
);
    import pcore_wrb_pkg::*;

    // x0 has no storage
    type_data_t regs [1:`PCORE_NREGS-1];
    logic       wr_en;

    assign wr_en = wrb2rf_i.rd_wr_req && (wrb2rf_i.rd_addr != '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < `PCORE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wrb2rf_i.rd_addr] <= wrb2rf_i.rd_data;
        end
    end

    // Shared by both read ports
    function automatic type_data_t read_port(input type_reg_addr_t addr);
        type_data_t data;
        if (addr == '0) begin
            data = '0;
        end else if (wr_en && (addr == wrb2rf_i.rd_addr)) begin
            // Same-cycle write is forwarded to the reader
            data = wrb2rf_i.rd_data;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

    // Relies on reset and on writes being qualified upstream
    a_rd_known: assert property (
        @(posedge clk) disable iff (reset_i) !$isunknown({rs1_data_o, rs2_data_o})
    );

endmodule : regfile_bypass

`default_nettype wire

// File: design/writeback.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcore_wrb_cfg.svh"

module writeback (
    mem2wrb_if.sink                         mem2wrb,
    output pcore_wrb_pkg::type_wrb2id_fb_s  wrb2rf_o,
    output pcore_wrb_pkg::type_data_t       wrb_rd_data_o
);
    import pcore_wrb_pkg::*;

    type_data_t wrb_rd_data;

    // Destination value mux
    always_comb begin
        wrb_rd_data = '0;
        case (mem2wrb.rd_wrb_sel)
            RD_WB_ALU: begin
                wrb_rd_data = mem2wrb.alu_result;
            end
            RD_WB_INC_PC: begin
                // Return address for jal and jalr, wraps at the top
                wrb_rd_data = mem2wrb.pc + `PCORE_XLEN'd4;
            end
            RD_WB_MEM: begin
                wrb_rd_data = mem2wrb.dmem_rdata;
            end
            RD_WB_CSR: begin
                wrb_rd_data = mem2wrb.csr_data;
            end
            default: begin
                wrb_rd_data = '0;
            end
        endcase
    end

    assign wrb2rf_o.rd_data   = wrb_rd_data;
    assign wrb2rf_o.rd_addr   = mem2wrb.rd_addr;
    // Stale records between handshakes must not write
    assign wrb2rf_o.rd_wr_req = mem2wrb.rd_wr_req && mem2wrb.valid;

    // Execute stage feedback
    assign wrb_rd_data_o = wrb_rd_data;

endmodule : writeback

`default_nettype wire

// File: design/mem2wrb_capture.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcore_wrb_cfg.svh"

module mem2wrb_capture (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic                            req_i,
    output logic                            ack_o,
    input  pcore_wrb_pkg::type_data_t       pc_i,
    input  pcore_wrb_pkg::type_data_t       alu_result_i,
    input  pcore_wrb_pkg::type_data_t       dmem_rdata_i,
    input  pcore_wrb_pkg::type_data_t       csr_data_i,
    input  pcore_wrb_pkg::type_reg_addr_t   rd_addr_i,
    input  logic                            rd_wr_req_i,
    input  pcore_wrb_pkg::type_rd_wrb_sel_e rd_wrb_sel_i,
    mem2wrb_if.source                       mem2wrb
);
    import pcore_wrb_pkg::*;

    type_capture_state_e state_q;
    type_capture_state_e state_d;
    logic                latch_en;

    // A new record is only taken from IDLE
    assign latch_en = (state_q == IDLE) && req_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_i) begin
                    state_d = PRESENT;
                end
            end
            PRESENT: begin
                // Record shown for its one cycle, now wait for the source
                state_d = req_i ? WAIT_REQ_LOW : IDLE;
            end
            WAIT_REQ_LOW: begin
                if (!req_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Payload, held stable until the next handshake
    always_ff @(posedge clk) begin
        if (latch_en) begin
            mem2wrb.pc         <= pc_i;
            mem2wrb.alu_result <= alu_result_i;
            mem2wrb.dmem_rdata <= dmem_rdata_i;
            mem2wrb.csr_data   <= csr_data_i;
            mem2wrb.rd_addr    <= rd_addr_i;
            mem2wrb.rd_wr_req  <= rd_wr_req_i;
            mem2wrb.rd_wrb_sel <= rd_wrb_sel_i;
        end
    end

    assign mem2wrb.valid = (state_q == PRESENT);
    assign ack_o         = (state_q != IDLE);

    // One register write per handshake
    a_valid_single: assert property (
        @(posedge clk) disable iff (reset_i) mem2wrb.valid |=> !mem2wrb.valid
    );

    // ack only drops after the source has released req
    a_ack_held: assert property (
        @(posedge clk) disable iff (reset_i) (ack_o && req_i) |=> ack_o
    );

endmodule : mem2wrb_capture

`default_nettype wire

// File: design/mem2wrb_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcore_wrb_cfg.svh"

interface mem2wrb_if;
    import pcore_wrb_pkg::*;

    // Qualifies the record, high for one cycle per handshake
    logic             valid;
    type_data_t       pc;
    type_data_t       alu_result;
    type_data_t       dmem_rdata;
    type_data_t       csr_data;
    type_reg_addr_t   rd_addr;
    logic             rd_wr_req;
    type_rd_wrb_sel_e rd_wrb_sel;

    modport source (
        output valid, pc, alu_result, dmem_rdata, csr_data,
        output rd_addr, rd_wr_req, rd_wrb_sel
    );

    modport sink (
        input valid, pc, alu_result, dmem_rdata, csr_data,
        input rd_addr, rd_wr_req, rd_wrb_sel
    );

endinterface : mem2wrb_if

`default_nettype wire

// File: design/pcore_wrb_pkg.sv
`default_nettype none

`include "pcore_wrb_cfg.svh"

package pcore_wrb_pkg;

    // Data words and pc values
    typedef logic [`PCORE_XLEN-1:0] type_data_t;

    // Register index, 5 bits for 32 registers
    typedef logic [$clog2(`PCORE_NREGS)-1:0] type_reg_addr_t;

    // Source of the destination register value
    typedef enum logic [1:0] {
        RD_WB_ALU    = 2'b00,
        RD_WB_INC_PC = 2'b01,
        RD_WB_MEM    = 2'b10,
        RD_WB_CSR    = 2'b11
    } type_rd_wrb_sel_e;

    // Handshake receiver states
    typedef enum logic [1:0] {
        IDLE,
        PRESENT,
        WAIT_REQ_LOW
    } type_capture_state_e;

    // Writeback result as seen by the register file
    typedef struct packed {
        type_data_t     rd_data;
        type_reg_addr_t rd_addr;
        logic           rd_wr_req;
    } type_wrb2id_fb_s;

endpackage : pcore_wrb_pkg

`default_nettype wire

// File: design/pcore_wrb_cfg.svh
`ifndef PCORE_WRB_CFG_SVH
`define PCORE_WRB_CFG_SVH

// Integer data path width, also used for pc values
`define PCORE_XLEN 32

// Architectural integer registers, x0 included
`define PCORE_NREGS 32

`endif
